/* rtl/saturn_pkg.sv */
package saturn_pkg;

    // widths that carry a meaning on the bus.
    typedef logic [3:0]  nibble_t;       // one nibble, the unit of every bus transfer.
    typedef logic [19:0] saturn_addr_t;  // nibble address, sent as five nibbles lsb first.

    // command nibbles, sent while is_data is low.
    localparam nibble_t cmd_load_pc  = 4'h2;  // next five data cycles load the pc.
    localparam nibble_t cmd_load_dp  = 4'h3;  // next five data cycles load the data pointer.
    localparam nibble_t cmd_pc_read  = 4'h4;  // each data cycle reads at pc, then pc moves on.
    localparam nibble_t cmd_dp_write = 4'h5;  // each data cycle writes at dp, then dp moves on.

    localparam int addr_nibbles = 5;  // address nibbles that follow a load command.

    // memory map.
    localparam saturn_addr_t mmio_base = 20'h00010;  // first nibble of the register block.
    localparam int mmio_size = 8;                     // register block length in nibbles.

    // the exercise run by the bus controller.
    localparam int      rom_dump_len = 32;    // nibbles read in the first read pass.
    localparam nibble_t write_key    = 4'hA;  // register i receives i ^ write_key.

    // controller sequence, one state per command and its data cycles.
    typedef enum logic [2:0] {
        st_load_pc0,  // pc <= 0.
        st_dump,      // read rom_dump_len nibbles from pc.
        st_load_dp,   // dp <= mmio_base.
        st_write,     // fill the register block.
        st_load_pc1,  // pc <= mmio_base.
        st_readback,  // read the register block back.
        st_halt       // one idle cycle, then halt.
    } ctrl_state_t;

endpackage

/* rtl/saturn_rom.sv */
`timescale 1ns/1ps

module saturn_rom
    import saturn_pkg::*;
#(
    parameter int rom_nibbles = 32
) (
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_phase_3,
    input  logic    i_bus_clk_en,
    input  logic    i_bus_is_data,
    input  nibble_t i_bus_nibble_in,
    output nibble_t o_bus_nibble_out
);

    localparam int rom_aw = $clog2(rom_nibbles);

    nibble_t      rom_mem [rom_nibbles];
    nibble_t      last_cmd;
    logic [2:0]   addr_left;  // address nibbles still to come.
    saturn_addr_t pc;
    logic         xfer;

    initial begin
        $readmemh("rtl/rom_image.hex", rom_mem);
    end

    assign xfer = i_bus_clk_en && i_phase_3;
    // the image repeats across the whole address space.
    assign o_bus_nibble_out = rom_mem[rom_aw'(pc % saturn_addr_t'(rom_nibbles))];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_cmd  <= 4'h0;
            addr_left <= 3'd0;
            pc        <= '0;
        end else if (xfer) begin
            if (!i_bus_is_data) begin
                last_cmd  <= i_bus_nibble_in;
                addr_left <= (i_bus_nibble_in == cmd_load_pc || i_bus_nibble_in == cmd_load_dp)
                             ? 3'(addr_nibbles) : 3'd0;
            end else if (addr_left != 3'd0) begin
                addr_left <= addr_left - 3'd1;  // shift in from the top, lsb arrives first.
                // the rom takes no writes, so data pointer loads are only counted.
                if (last_cmd == cmd_load_pc) pc <= {i_bus_nibble_in, pc[19:4]};
            end else if (last_cmd == cmd_pc_read) begin
                pc <= pc + 20'd1;
            end
        end
    end

endmodule

/* rtl/saturn_mmio.sv */
`timescale 1ns/1ps

module saturn_mmio
    import saturn_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_phase_3,
    input  logic    i_bus_clk_en,
    input  logic    i_bus_is_data,
    input  nibble_t i_bus_nibble_in,
    input  logic    i_bus_daisy,
    output nibble_t o_bus_nibble_out,
    output logic    o_bus_daisy,
    output logic    o_bus_active
);

    localparam int mmio_aw = $clog2(mmio_size);

    nibble_t      regs [mmio_size];
    nibble_t      last_cmd;
    logic [2:0]   addr_left;
    saturn_addr_t pc;
    saturn_addr_t dp;
    saturn_addr_t pc_off;    // pointers relative to the block base.
    saturn_addr_t dp_off;
    logic         pc_in;
    logic         dp_in;
    logic         data_phase;  // a data cycle past any address load.
    logic         xfer;

    assign xfer       = i_bus_clk_en && i_phase_3;
    assign pc_off     = pc - mmio_base;
    assign dp_off     = dp - mmio_base;
    assign pc_in      = pc_off < saturn_addr_t'(mmio_size);  // below base wraps to a big offset.
    assign dp_in      = dp_off < saturn_addr_t'(mmio_size);
    assign data_phase = i_bus_is_data && (addr_left == 3'd0);

    assign o_bus_nibble_out = regs[pc_off[mmio_aw-1:0]];
    assign o_bus_active = i_bus_daisy && data_phase && (last_cmd == cmd_pc_read) && pc_in;
    assign o_bus_daisy  = i_bus_daisy && !o_bus_active;  // chain held low while we drive.

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_cmd  <= 4'h0;
            addr_left <= 3'd0;
            pc        <= '0;
            dp        <= '0;
            for (int i = 0; i < mmio_size; i++) regs[i] <= 4'h0;
        end else if (xfer) begin
            if (!i_bus_is_data) begin
                last_cmd  <= i_bus_nibble_in;
                addr_left <= (i_bus_nibble_in == cmd_load_pc || i_bus_nibble_in == cmd_load_dp)
                             ? 3'(addr_nibbles) : 3'd0;
            end else if (addr_left != 3'd0) begin
                addr_left <= addr_left - 3'd1;
                if (last_cmd == cmd_load_pc) pc <= {i_bus_nibble_in, pc[19:4]};
                else dp <= {i_bus_nibble_in, dp[19:4]};
            end else if (last_cmd == cmd_pc_read) begin
                pc <= pc + 20'd1;  // pointers track even outside the window.
            end else if (last_cmd == cmd_dp_write) begin
                if (i_bus_daisy && dp_in) regs[dp_off[mmio_aw-1:0]] <= i_bus_nibble_in;
                dp <= dp + 20'd1;
            end
        end
    end

endmodule

/* rtl/saturn_bus_controller.sv */
`timescale 1ns/1ps

module saturn_bus_controller
    import saturn_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_clk_en,
    input  logic       i_reset,
    input  logic [3:0] i_phases,
    input  nibble_t    i_bus_nibble_in,
    input  logic       i_serial_busy,
    output logic       o_bus_clk_en,
    output logic       o_bus_is_data,
    output nibble_t    o_bus_nibble_out,
    output logic       o_debug_cycle,
    output logic       o_instr_decoded,
    output logic [7:0] o_char_to_send,
    output logic [9:0] o_char_counter,
    output logic       o_char_valid,
    output logic       o_char_send,
    output logic       o_halt
);

    ctrl_state_t  state;
    ctrl_state_t  next_state;
    logic [5:0]   sub_cnt;     // 0 is the command cycle, then data cycles 1 to last_sub.
    logic [5:0]   last_sub;
    logic [2:0]   data_idx;    // data cycle index counted from 0.
    logic         xfer;        // the transfer edge of the current bus cycle.
    logic         read_cycle;
    logic         captured;    // a read nibble waits for conversion.
    nibble_t      rd_nibble;
    nibble_t      cmd_nibble;
    saturn_addr_t load_addr;

    assign xfer       = i_clk_en && o_bus_clk_en && (i_phases == 4'b1000);
    assign data_idx   = 3'(sub_cnt - 6'd1);
    assign read_cycle = (state == st_dump || state == st_readback) && o_bus_is_data;

    assign o_bus_clk_en    = !o_halt;       // the bus only stops once we are done.
    assign o_debug_cycle   = o_char_valid;  // stall the ring while a character waits.
    assign o_instr_decoded = captured;
    assign o_char_send     = o_char_valid && !i_serial_busy;

    // per state command, length and successor.
    always_comb begin
        cmd_nibble = 4'h0;  // halt cycle sends a command no device knows.
        last_sub   = 6'd0;
        next_state = st_halt;
        load_addr  = mmio_base;
        case (state)
            st_load_pc0: begin
                cmd_nibble = cmd_load_pc;
                last_sub   = 6'(addr_nibbles);
                next_state = st_dump;
                load_addr  = '0;  // the dump starts at the bottom of the rom.
            end
            st_dump: begin
                cmd_nibble = cmd_pc_read;
                last_sub   = 6'(rom_dump_len);
                next_state = st_load_dp;
            end
            st_load_dp: begin
                cmd_nibble = cmd_load_dp;
                last_sub   = 6'(addr_nibbles);
                next_state = st_write;
            end
            st_write: begin
                cmd_nibble = cmd_dp_write;
                last_sub   = 6'(mmio_size);
                next_state = st_load_pc1;
            end
            st_load_pc1: begin
                cmd_nibble = cmd_load_pc;
                last_sub   = 6'(addr_nibbles);
                next_state = st_readback;
            end
            st_readback: begin
                cmd_nibble = cmd_pc_read;
                last_sub   = 6'(mmio_size);
                next_state = st_halt;
            end
            default: begin
            end
        endcase
    end

    // outputs stay put for the whole bus cycle since state only moves on xfer.
    always_comb begin
        o_bus_is_data    = (sub_cnt != 6'd0);
        o_bus_nibble_out = cmd_nibble;
        if (o_bus_is_data) begin
            case (state)
                st_load_pc0, st_load_dp, st_load_pc1:  // address goes out lsb first.
                    o_bus_nibble_out = nibble_t'(load_addr >> {data_idx, 2'b00});
                st_write:
                    o_bus_nibble_out = nibble_t'({1'b0, data_idx}) ^ write_key;
                default:
                    o_bus_nibble_out = 4'h0;  // read cycles, the device drives.
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= st_load_pc0;
            sub_cnt <= 6'd0;
            o_halt  <= 1'b0;
        end else if (xfer) begin
            if (state == st_halt) begin
                o_halt <= 1'b1;  // the last character has left by now.
            end else if (sub_cnt == last_sub) begin
                sub_cnt <= 6'd0;
                state   <= next_state;
            end else begin
                sub_cnt <= sub_cnt + 6'd1;
            end
        end
    end

    // capture, then valid, then send when the port is free.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            captured       <= 1'b0;
            o_char_valid   <= 1'b0;
            o_char_counter <= 10'd0;
        end else begin
            captured <= xfer && read_cycle;
            if (captured) begin
                o_char_valid <= 1'b1;
            end else if (o_char_send) begin
                o_char_valid   <= 1'b0;
                o_char_counter <= o_char_counter + 10'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (xfer && read_cycle) rd_nibble <= i_bus_nibble_in;
        if (captured) begin  // hex digit to ascii.
            o_char_to_send <= (rd_nibble < 4'd10) ? 8'd48 + {4'd0, rd_nibble}
                                                  : 8'd55 + {4'd0, rd_nibble};
        end
    end

endmodule

/* rtl/saturn_bus.sv */
`timescale 1ns/1ps

module saturn_bus
    import saturn_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_clk_en,
    input  logic        i_reset,
    input  logic        i_serial_busy,
    output logic        o_halt,
    output logic [1:0]  o_phase,
    output logic [31:0] o_cycle_ctr,
    output logic        o_instr_decoded,
    output logic        o_debug_cycle,
    output logic [7:0]  o_char_to_send,
    output logic [9:0]  o_char_counter,
    output logic        o_char_valid,
    output logic        o_char_send
);

    logic [3:0]  phases;           // one-hot phase ring, bit 0 is phase 0.
    logic [31:0] cycle_ctr;        // completed bus cycles.
    logic        bus_clk_en;       // clocks on which bus parties may act.
    logic        ctrl_bus_clk_en;
    logic        ctrl_bus_is_data;
    nibble_t     ctrl_bus_nibble_out;
    nibble_t     ctrl_bus_nibble_in;
    logic        ctrl_halt;
    nibble_t     rom_bus_nibble_out;
    nibble_t     mmio_bus_nibble_out;
    logic        mmio_active;

    assign bus_clk_en  = i_clk_en && ctrl_bus_clk_en;
    assign o_halt      = ctrl_halt;
    assign o_cycle_ctr = cycle_ctr;

    // the firmware rom sits on the bus at all times and needs no configuration.
    saturn_rom #(
        .rom_nibbles (32)
    ) u_rom (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_phase_3        (phases[3]),
        .i_bus_clk_en     (bus_clk_en),
        .i_bus_is_data    (ctrl_bus_is_data),
        .i_bus_nibble_in  (ctrl_bus_nibble_out),
        .o_bus_nibble_out (rom_bus_nibble_out)
    );

    // the register block is first and only device on the daisy chain.
    saturn_mmio u_mmio (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_phase_3        (phases[3]),
        .i_bus_clk_en     (bus_clk_en),
        .i_bus_is_data    (ctrl_bus_is_data),
        .i_bus_nibble_in  (ctrl_bus_nibble_out),
        .i_bus_daisy      (1'b1),  // head of the chain is always enabled.
        .o_bus_nibble_out (mmio_bus_nibble_out),
        .o_bus_daisy      (),      // nothing follows on the chain.
        .o_bus_active     (mmio_active)
    );

    // bus master standing in for the processor.
    saturn_bus_controller u_ctrl (
        .i_clk            (i_clk),
        .i_clk_en         (i_clk_en),
        .i_reset          (i_reset),
        .i_phases         (phases),
        .i_bus_nibble_in  (ctrl_bus_nibble_in),
        .i_serial_busy    (i_serial_busy),
        .o_bus_clk_en     (ctrl_bus_clk_en),
        .o_bus_is_data    (ctrl_bus_is_data),
        .o_bus_nibble_out (ctrl_bus_nibble_out),
        .o_debug_cycle    (o_debug_cycle),
        .o_instr_decoded  (o_instr_decoded),
        .o_char_to_send   (o_char_to_send),
        .o_char_counter   (o_char_counter),
        .o_char_valid     (o_char_valid),
        .o_char_send      (o_char_send),
        .o_halt           (ctrl_halt)
    );

    // an active mmio block overrides the rom.
    assign ctrl_bus_nibble_in = mmio_active ? mmio_bus_nibble_out : rom_bus_nibble_out;

    always_comb begin
        o_phase = 2'd0;  // encode the ring for the outside world.
        if (phases[1]) o_phase = 2'd1;
        if (phases[2]) o_phase = 2'd2;
        if (phases[3]) o_phase = 2'd3;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phases    <= 4'b0001;
            cycle_ctr <= 32'd0;
        end else begin
            if (i_clk_en && !o_debug_cycle) begin  // a debug cycle freezes the ring.
                phases    <= {phases[2:0], phases[3]};
                cycle_ctr <= cycle_ctr + {31'd0, phases[3]};  // counts on wrap to phase 0.
            end
        end
    end

endmodule

/* tb/saturn_bus_tb.sv */
`timescale 1ns/1ps

module saturn_bus_tb
    import saturn_pkg::*;
();

    localparam int total_chars  = rom_dump_len + mmio_size;  // dump plus read-back.
    localparam int halt_timeout = 20000;                     // clocks allowed until halt.
    localparam int drain_cycles = 200;                       // clocks watched after halt.

    logic        i_clk = 1'b0;
    logic        i_clk_en = 1'b0;
    logic        i_reset = 1'b1;        // held from time zero.
    logic        i_serial_busy = 1'b0;
    logic        o_halt;
    logic [1:0]  o_phase;
    logic [31:0] o_cycle_ctr;
    logic        o_instr_decoded;
    logic        o_debug_cycle;
    logic [7:0]  o_char_to_send;
    logic [9:0]  o_char_counter;
    logic        o_char_valid;
    logic        o_char_send;

    integer      seed = 34183;
    int          mismatch_errs = 0;
    int          other_errs = 0;
    int          chars_seen = 0;    // send strobes observed so far.
    int          decodes_seen = 0;  // clocks with the decode strobe high.
    logic        have_prev = 1'b0;  // previous sample belongs to the running bus.
    logic        prev_debug;
    logic [1:0]  prev_phase;
    logic [31:0] prev_ctr;

    saturn_bus UUT (
        .i_clk           (i_clk),
        .i_clk_en        (i_clk_en),
        .i_reset         (i_reset),
        .i_serial_busy   (i_serial_busy),
        .o_halt          (o_halt),
        .o_phase         (o_phase),
        .o_cycle_ctr     (o_cycle_ctr),
        .o_instr_decoded (o_instr_decoded),
        .o_debug_cycle   (o_debug_cycle),
        .o_char_to_send  (o_char_to_send),
        .o_char_counter  (o_char_counter),
        .o_char_valid    (o_char_valid),
        .o_char_send     (o_char_send)
    );

    always #20 i_clk = ~i_clk;  // 40 ns period.

    // ascii code of character k as the bus exercise should produce it.
    function logic [7:0] expected_char(input int k);
        nibble_t image [rom_dump_len];
        nibble_t n;
        $readmemh("rtl/rom_image.hex", image);
        if (k >= int'(mmio_base) && k < int'(mmio_base) + mmio_size) begin
            n = 4'h0;  // the register block answers there with its reset contents.
        end else if (k < rom_dump_len) begin
            n = image[5'(k)];
        end else begin
            n = nibble_t'(k - rom_dump_len) ^ write_key;  // read-back of the written pattern.
        end
        if (n < 4'd10) return 8'd48 + {4'd0, n};  // digits 0 to 9.
        return 8'd55 + {4'd0, n};                  // letters A to F.
    endfunction

    // enable and busy change only on rising edges.
    always @(posedge i_clk) begin
        i_clk_en      <= (($random(seed) & 3) != 0);  // high on three clocks in four on average.
        i_serial_busy <= (($random(seed) & 1) != 0);
    end

    // serial side, sampled mid-cycle where the strobes are settled.
    always @(negedge i_clk) begin
        if (!i_reset) begin
            if (o_instr_decoded) decodes_seen++;  // one clock per nibble read.
            assert (!(o_char_send && i_serial_busy)) else begin
                other_errs++;
                $display("send strobe raised while the serial port was busy at %0t", $time);
            end
            assert (o_char_counter == 10'(chars_seen)) else begin
                mismatch_errs++;
                $display("mismatch at %0t: char counter %0d after %0d send strobes",
                         $time, o_char_counter, chars_seen);
            end
            if (o_char_send) begin
                assert (!o_halt) else begin
                    other_errs++;
                    $display("a character was sent after halt at %0t", $time);
                end
                assert (chars_seen < total_chars) else begin
                    other_errs++;
                    $display("more than %0d characters were sent", total_chars);
                end
                assert (o_char_to_send == expected_char(chars_seen)) else begin
                    mismatch_errs++;
                    $display("mismatch at %0t: char %0d is 0x%02h, expected 0x%02h",
                             $time, chars_seen, o_char_to_send, expected_char(chars_seen));
                end
                chars_seen++;  // the counter follows on the next edge.
            end
        end
    end

    // phase ring and cycle counter, compared with the previous mid-cycle sample.
    always @(negedge i_clk) begin
        if (!i_reset && have_prev) begin
            if (prev_debug) begin  // a stall must freeze the whole bus.
                assert (o_phase == prev_phase && o_cycle_ctr == prev_ctr) else begin
                    mismatch_errs++;
                    $display("mismatch at %0t: bus moved in a debug cycle, phase %0d to %0d",
                             $time, prev_phase, o_phase);
                end
            end
            if (prev_phase == 2'd3 && o_phase == 2'd0) begin
                assert (o_cycle_ctr == prev_ctr + 32'd1) else begin
                    mismatch_errs++;
                    $display("mismatch at %0t: cycle counter %0d after wrap from %0d",
                             $time, o_cycle_ctr, prev_ctr);
                end
            end else begin
                assert (o_cycle_ctr == prev_ctr) else begin
                    mismatch_errs++;
                    $display("mismatch at %0t: cycle counter moved without a wrap", $time);
                end
            end
        end
        have_prev  = !i_reset;
        prev_debug = o_debug_cycle;
        prev_phase = o_phase;
        prev_ctr   = o_cycle_ctr;
    end

    initial begin
        int wait_cycles;
        repeat (8) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);  // the first edge out of reset is still ahead.
        assert (!o_halt && !o_char_valid && !o_char_send && !o_debug_cycle && !o_instr_decoded
                && o_char_counter == 10'd0 && o_phase == 2'd0 && o_cycle_ctr == 32'd0) else begin
            mismatch_errs++;
            $display("mismatch at %0t: outputs not at their reset values", $time);
        end
        wait_cycles = 0;
        while (!o_halt && wait_cycles < halt_timeout) begin
            @(negedge i_clk);
            wait_cycles++;
        end
        if (!o_halt) begin
            other_errs++;
            $display("halt did not rise within %0d clocks", halt_timeout);
        end else begin
            assert (chars_seen == total_chars) else begin
                mismatch_errs++;
                $display("mismatch at %0t: halt after %0d characters, expected %0d",
                         $time, chars_seen, total_chars);
            end
            repeat (drain_cycles) @(negedge i_clk);  // late strobes are caught by the checker.
            assert (decodes_seen == total_chars) else begin
                mismatch_errs++;
                $display("mismatch at %0t: %0d decode strobes, expected %0d",
                         $time, decodes_seen, total_chars);
            end
        end
        $display("errors: %0d mismatches, %0d other failures, %0d characters checked",
                 mismatch_errs, other_errs, chars_seen);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
rtl/saturn_pkg.sv
rtl/saturn_rom.sv
rtl/saturn_mmio.sv
rtl/saturn_bus_controller.sv
rtl/saturn_bus.sv
tb/saturn_bus_tb.sv

/* Makefile */
# Verilator flow for the nibble bus testbench.
VERILATOR ?= verilator
TOP       ?= saturn_bus_tb
SEED      ?= 34183
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* rtl/rom_image.hex */
// one firmware nibble per line in hex, entry 0 first.
3
F
1
A
8
0
C
5
E
2
9
7
B
4
D
6
5
A
C
3
E
9
1
F
0
8
B
2
D
4
6
C
